//--- design/axi_chan_pkg.sv
// AXI4 channel types for a 16-bit address, 32-bit data slave with INCR bursts and no sidebands.
package axi_chan_pkg;

  // Channel field widths.
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned LEN_W  = 8;
  localparam int unsigned SIZE_W = 3;

  // Field types.
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [SIZE_W-1:0] size_t;
  typedef logic [1:0]        resp_t;

  // Only OKAY and SLVERR are ever returned.
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // AR and AW payload.
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    size_t size;
  } ax_chan_t;

  // W payload, last is implied by the burst length.
  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  // R payload.
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  // B payload.
  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

endpackage

//--- design/mem_port_pkg.sv
// Memory port and beat stream types; the memory must answer every grant once, in order.
package mem_port_pkg;

  // Beats in flight between grant and AXI response.
  localparam int unsigned BUF_DEPTH = 4;

  // One word access on the memory port.
  typedef struct packed {
    axi_chan_pkg::addr_t addr;
    axi_chan_pkg::data_t wdata;
    axi_chan_pkg::strb_t strb;
    logic                we;
  } mem_req_t;

  // Memory answer, sent for reads and writes alike.
  typedef struct packed {
    axi_chan_pkg::data_t rdata;
    logic                err;
  } mem_rsp_t;

  // What the router needs to turn an answer into R or B.
  typedef struct packed {
    axi_chan_pkg::id_t id;
    logic              last;
    logic              write;
  } beat_meta_t;

  // Beat offered by a burst generator.
  typedef struct packed {
    mem_req_t   req;
    beat_meta_t meta;
  } beat_t;

endpackage

//--- design/beat_fifo.sv
// Fall-through FIFO; the writer must not push while full_o is high.
module beat_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  payload_t data_i,
  input  logic     push_i,
  output logic     full_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     pop_i
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  payload_t mem_q [DEPTH];
  ptr_t     wr_ptr_q, rd_ptr_q;
  cnt_t     cnt_q;
  logic     empty;
  logic     wr_en, rd_en;

  assign empty  = (cnt_q == '0);
  assign full_o = (cnt_q == cnt_t'(DEPTH));

  // An empty FIFO shows the incoming word directly.
  assign valid_o = !empty || push_i;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];

  // A word that passes straight through is never stored.
  assign wr_en = push_i && !(empty && pop_i);
  assign rd_en = pop_i && !empty;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + cnt_t'(wr_en) - cnt_t'(rd_en);
    end
  end

  // Storage.
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- design/rd_burst_gen.sv
// Expands AR into read beats; bursts are treated as INCR whatever the AXI burst type.
module rd_burst_gen (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  axi_chan_pkg::ax_chan_t ar_i,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  output mem_port_pkg::beat_t    beat_o,
  output logic                   beat_valid_o,
  input  logic                   beat_ready_i,
  output logic                   burst_active_o
);

  // Beats left after the one last issued.
  axi_chan_pkg::len_t  cnt_d, cnt_q;
  // Address of the last issued beat, aligned to the size.
  axi_chan_pkg::addr_t addr_d, addr_q;
  axi_chan_pkg::addr_t next_addr;
  axi_chan_pkg::id_t   id_d, id_q;
  axi_chan_pkg::size_t size_d, size_q;

  assign burst_active_o = (cnt_q != '0);
  assign next_addr      = addr_q + (axi_chan_pkg::addr_t'(1) << size_q);

  always_comb begin
    ar_ready_o   = 1'b0;
    beat_valid_o = 1'b0;
    beat_o       = '0;
    cnt_d        = cnt_q;
    addr_d       = addr_q;
    id_d         = id_q;
    size_d       = size_q;
    if (burst_active_o) begin
      // Later beats of a running burst.
      beat_valid_o     = 1'b1;
      beat_o.req.addr  = next_addr;
      beat_o.meta.id   = id_q;
      beat_o.meta.last = (cnt_q == axi_chan_pkg::len_t'(1));
      if (beat_ready_i) begin
        cnt_d  = cnt_q - 1'b1;
        addr_d = next_addr;
      end
    end else if (ar_valid_i) begin
      // First beat goes out on the unaligned address.
      beat_valid_o     = 1'b1;
      beat_o.req.addr  = ar_i.addr;
      beat_o.meta.id   = ar_i.id;
      beat_o.meta.last = (ar_i.len == '0);
      if (beat_ready_i) begin
        ar_ready_o = 1'b1;
        cnt_d      = ar_i.len;
        addr_d     = ar_i.addr & ~((axi_chan_pkg::addr_t'(1) << ar_i.size) - 1'b1);
        id_d       = ar_i.id;
        size_d     = ar_i.size;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Burst payload.
  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    id_q   <= id_d;
    size_q <= size_d;
  end

endmodule

//--- design/wr_burst_gen.sv
// Expands AW plus W into write beats; W must follow AW in order, and bursts are INCR only.
module wr_burst_gen (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  axi_chan_pkg::ax_chan_t aw_i,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  axi_chan_pkg::w_chan_t  w_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  output mem_port_pkg::beat_t    beat_o,
  output logic                   beat_valid_o,
  input  logic                   beat_ready_i,
  output logic                   burst_active_o
);

  // Beats left after the one last issued.
  axi_chan_pkg::len_t  cnt_d, cnt_q;
  // Address of the last issued beat, aligned to the size.
  axi_chan_pkg::addr_t addr_d, addr_q;
  axi_chan_pkg::addr_t next_addr;
  axi_chan_pkg::id_t   id_d, id_q;
  axi_chan_pkg::size_t size_d, size_q;

  assign burst_active_o = (cnt_q != '0);
  assign next_addr      = addr_q + (axi_chan_pkg::addr_t'(1) << size_q);

  always_comb begin
    aw_ready_o   = 1'b0;
    w_ready_o    = 1'b0;
    beat_valid_o = 1'b0;
    beat_o       = '0;
    cnt_d        = cnt_q;
    addr_d       = addr_q;
    id_d         = id_q;
    size_d       = size_q;
    // Data and strobe always come from W.
    beat_o.req.wdata  = w_i.data;
    beat_o.req.strb   = w_i.strb;
    beat_o.req.we     = 1'b1;
    beat_o.meta.write = 1'b1;
    if (burst_active_o) begin
      // Wait for W on every later beat.
      beat_valid_o     = w_valid_i;
      beat_o.req.addr  = next_addr;
      beat_o.meta.id   = id_q;
      beat_o.meta.last = (cnt_q == axi_chan_pkg::len_t'(1));
      if (w_valid_i && beat_ready_i) begin
        w_ready_o = 1'b1;
        cnt_d     = cnt_q - 1'b1;
        addr_d    = next_addr;
      end
    end else if (aw_valid_i && w_valid_i) begin
      // First beat needs AW and W together.
      beat_valid_o     = 1'b1;
      beat_o.req.addr  = aw_i.addr;
      beat_o.meta.id   = aw_i.id;
      beat_o.meta.last = (aw_i.len == '0);
      if (beat_ready_i) begin
        aw_ready_o = 1'b1;
        w_ready_o  = 1'b1;
        cnt_d      = aw_i.len;
        addr_d     = aw_i.addr & ~((axi_chan_pkg::addr_t'(1) << aw_i.size) - 1'b1);
        id_d       = aw_i.id;
        size_d     = aw_i.size;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    id_q   <= id_d;
    size_q <= size_d;
  end

endmodule

//--- design/beat_arbiter.sv
// Picks a read or write beat for the memory port; sources must hold a beat until it is taken.
module beat_arbiter (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  mem_port_pkg::beat_t           rd_beat_i,
  input  logic                          rd_valid_i,
  output logic                          rd_ready_o,
  input  logic                          rd_active_i,
  input  mem_port_pkg::beat_t           wr_beat_i,
  input  logic                          wr_valid_i,
  output logic                          wr_ready_o,
  input  logic                          wr_active_i,
  input  logic                          meta_ready_i,
  output mem_port_pkg::mem_req_t        mem_req_o,
  output logic                          mem_req_valid_o,
  input  logic                          mem_gnt_i,
  output mem_port_pkg::beat_meta_t      meta_o,
  output logic                          meta_push_o
);

  // High selects the write stream.
  logic                sel, sel_q;
  logic                lock_q;
  // Stream preferred on the next tie.
  logic                rr_q;
  logic                arb_valid;
  logic                accept;
  mem_port_pkg::beat_t beat;

  always_comb begin
    if (lock_q) begin
      sel = sel_q;
    end else if (rd_valid_i ^ wr_valid_i) begin
      sel = wr_valid_i;
    end else if (rd_valid_i && wr_valid_i) begin
      // Running bursts first, write before read.
      if (wr_active_i) begin
        sel = 1'b1;
      end else if (rd_active_i) begin
        sel = 1'b0;
      end else begin
        sel = rr_q;
      end
    end else begin
      sel = rr_q;
    end
  end

  assign beat      = sel ? wr_beat_i : rd_beat_i;
  assign arb_valid = sel ? wr_valid_i : rd_valid_i;

  // No request without room for its meta entry.
  assign mem_req_valid_o = arb_valid && meta_ready_i;
  assign accept          = mem_req_valid_o && mem_gnt_i;
  assign mem_req_o       = beat.req;

  // Meta goes to the router in the grant cycle.
  assign meta_o      = beat.meta;
  assign meta_push_o = accept;

  assign rd_ready_o = accept && !sel;
  assign wr_ready_o = accept && sel;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
      rr_q   <= 1'b0;
    end else begin
      sel_q <= sel;
      // Hold the choice until the beat is taken.
      if (accept) begin
        lock_q <= 1'b0;
        rr_q   <= !sel;
      end else if (arb_valid) begin
        lock_q <= 1'b1;
      end
    end
  end

endmodule

//--- design/resp_router.sv
// Pairs memory answers with beat meta in order; at most BUF_DEPTH beats may be outstanding.
module resp_router (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  mem_port_pkg::beat_meta_t      meta_i,
  input  logic                          meta_push_i,
  output logic                          meta_ready_o,
  input  mem_port_pkg::mem_rsp_t        mem_rsp_i,
  input  logic                          mem_rvalid_i,
  output axi_chan_pkg::r_chan_t         r_o,
  output logic                          r_valid_o,
  input  logic                          r_ready_i,
  output axi_chan_pkg::b_chan_t         b_o,
  output logic                          b_valid_o,
  input  logic                          b_ready_i
);

  mem_port_pkg::beat_meta_t meta_head;
  mem_port_pkg::mem_rsp_t   rsp_head;
  logic                     meta_full;
  logic                     meta_valid, rsp_valid;
  logic                     pair_valid;
  logic                     sel_r, sel_b;
  logic                     pop;
  // Error seen on an earlier beat of the current write burst.
  logic                     wr_err_q;
  logic                     err_sum;

  // Beat meta in grant order.
  beat_fifo #(
    .payload_t ( mem_port_pkg::beat_meta_t ),
    .DEPTH     ( mem_port_pkg::BUF_DEPTH   )
  ) meta_fifo_inst (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .data_i   ( meta_i      ),
    .push_i   ( meta_push_i ),
    .full_o   ( meta_full   ),
    .data_o   ( meta_head   ),
    .valid_o  ( meta_valid  ),
    .pop_i    ( pop         )
  );

  // Memory answers, never more than the meta entries.
  beat_fifo #(
    .payload_t ( mem_port_pkg::mem_rsp_t ),
    .DEPTH     ( mem_port_pkg::BUF_DEPTH )
  ) rsp_fifo_inst (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .data_i   ( mem_rsp_i    ),
    .push_i   ( mem_rvalid_i ),
    .full_o   (              ),
    .data_o   ( rsp_head     ),
    .valid_o  ( rsp_valid    ),
    .pop_i    ( pop          )
  );

  assign meta_ready_o = !meta_full;

  // Reads go to R, only the last write beat goes to B.
  assign pair_valid = meta_valid && rsp_valid;
  assign sel_r      = !meta_head.write;
  assign sel_b      = meta_head.write && meta_head.last;
  assign r_valid_o  = pair_valid && sel_r;
  assign b_valid_o  = pair_valid && sel_b;

  // Inner write beats drain without an AXI handshake.
  assign pop = pair_valid && (sel_r ? r_ready_i : (sel_b ? b_ready_i : 1'b1));

  assign err_sum = wr_err_q || rsp_head.err;

  always_comb begin
    r_o      = '0;
    r_o.id   = meta_head.id;
    r_o.data = rsp_head.rdata;
    r_o.last = meta_head.last;
    r_o.resp = rsp_head.err ? axi_chan_pkg::RESP_SLVERR : axi_chan_pkg::RESP_OKAY;
    b_o      = '0;
    b_o.id   = meta_head.id;
    b_o.resp = err_sum ? axi_chan_pkg::RESP_SLVERR : axi_chan_pkg::RESP_OKAY;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_err_q <= 1'b0;
    end else if (pop && meta_head.write) begin
      // Cleared once B has gone out.
      wr_err_q <= sel_b ? 1'b0 : err_sum;
    end
  end

endmodule

//--- design/axi_to_mem.sv
// AXI4 slave to single-word memory port; INCR bursts only, with up to BUF_DEPTH beats in flight.
module axi_to_mem (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  axi_chan_pkg::ax_chan_t ar_i,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  axi_chan_pkg::ax_chan_t aw_i,
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  axi_chan_pkg::w_chan_t  w_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  output axi_chan_pkg::r_chan_t  r_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output axi_chan_pkg::b_chan_t  b_o,
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  output mem_port_pkg::mem_req_t mem_req_o,
  output logic                   mem_req_valid_o,
  input  logic                   mem_gnt_i,
  input  mem_port_pkg::mem_rsp_t mem_rsp_i,
  input  logic                   mem_rvalid_i
);

  mem_port_pkg::beat_t      rd_beat, wr_beat;
  logic                     rd_valid, rd_ready, rd_active;
  logic                     wr_valid, wr_ready, wr_active;
  mem_port_pkg::beat_meta_t meta;
  logic                     meta_push, meta_ready;

  // Read beat source.
  rd_burst_gen rd_burst_gen_inst (
    .clk_i, .arst_n_i, .ar_i, .ar_valid_i, .ar_ready_o,
    .beat_o       ( rd_beat   ),
    .beat_valid_o ( rd_valid  ),
    .beat_ready_i ( rd_ready  ),
    .burst_active_o ( rd_active )
  );

  // Write beat source.
  wr_burst_gen wr_burst_gen_inst (
    .clk_i, .arst_n_i, .aw_i, .aw_valid_i, .aw_ready_o, .w_i, .w_valid_i, .w_ready_o,
    .beat_o       ( wr_beat   ),
    .beat_valid_o ( wr_valid  ),
    .beat_ready_i ( wr_ready  ),
    .burst_active_o ( wr_active )
  );

  // Shares the memory port.
  beat_arbiter beat_arbiter_inst (
    .clk_i, .arst_n_i,
    .rd_beat_i ( rd_beat ), .rd_valid_i ( rd_valid ), .rd_ready_o ( rd_ready ),
    .rd_active_i ( rd_active ),
    .wr_beat_i ( wr_beat ), .wr_valid_i ( wr_valid ), .wr_ready_o ( wr_ready ),
    .wr_active_i ( wr_active ),
    .meta_ready_i ( meta_ready ),
    .mem_req_o, .mem_req_valid_o, .mem_gnt_i,
    .meta_o ( meta ), .meta_push_o ( meta_push )
  );

  // Turns memory answers into R and B.
  resp_router resp_router_inst (
    .clk_i, .arst_n_i,
    .meta_i ( meta ), .meta_push_i ( meta_push ), .meta_ready_o ( meta_ready ),
    .mem_rsp_i, .mem_rvalid_i,
    .r_o, .r_valid_o, .r_ready_i,
    .b_o, .b_valid_o, .b_ready_i
  );

endmodule

//--- tests/axi_to_mem_chk.sv
// Handshake stability checks on the bridge ports; silent while reset is asserted.
module axi_to_mem_chk (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input mem_port_pkg::mem_req_t req_i,
  input logic                   req_valid_i,
  input logic                   gnt_i,
  input axi_chan_pkg::r_chan_t  r_i,
  input logic                   r_valid_i,
  input logic                   r_ready_i,
  input axi_chan_pkg::b_chan_t  b_i,
  input logic                   b_valid_i,
  input logic                   b_ready_i
);

  // A memory request may not change or drop before its grant.
  property req_hold_p;
    @(posedge clk_i) disable iff (!arst_n_i)
      (req_valid_i && !gnt_i) |=> (req_valid_i && $stable(req_i));
  endproperty

  // R and B payloads hold while the master stalls.
  property r_hold_p;
    @(posedge clk_i) disable iff (!arst_n_i)
      (r_valid_i && !r_ready_i) |=> (r_valid_i && $stable(r_i));
  endproperty

  property b_hold_p;
    @(posedge clk_i) disable iff (!arst_n_i)
      (b_valid_i && !b_ready_i) |=> (b_valid_i && $stable(b_i));
  endproperty

  req_hold_a: assert property (req_hold_p) else $error("mem_req_o changed before grant");
  r_hold_a:   assert property (r_hold_p) else $error("r_o changed while stalled");
  b_hold_a:   assert property (b_hold_p) else $error("b_o changed while stalled");

endmodule

//--- tests/axi_to_mem_tb.sv
// Self-checking bench for the AXI to memory bridge; word memory, errors at and above ERR_BASE.
module axi_to_mem_tb;

  localparam axi_chan_pkg::addr_t ERR_BASE = 16'hf000;
  localparam int unsigned         TIMEOUT  = 2000;
  localparam int unsigned         WORDS    = 16384;
  localparam logic [31:0]         SEED     = 32'hf844_54b5;

  logic                   clk_i, arst_n_i;
  axi_chan_pkg::ax_chan_t ar_i, aw_i;
  logic                   ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o;
  axi_chan_pkg::w_chan_t  w_i;
  logic                   w_valid_i, w_ready_o;
  axi_chan_pkg::r_chan_t  r_o;
  logic                   r_valid_o;
  logic                   r_ready_i = 1'b1;
  axi_chan_pkg::b_chan_t  b_o;
  logic                   b_valid_o;
  logic                   b_ready_i = 1'b1;
  mem_port_pkg::mem_req_t mem_req_o;
  logic                   mem_req_valid_o;
  logic                   mem_gnt_i = 1'b0;
  mem_port_pkg::mem_rsp_t mem_rsp_i = '0;
  logic                   mem_rvalid_i = 1'b0;

  // Memory model state and the values it drives on the next rising edge.
  logic [31:0]            mem [WORDS];
  logic [31:0]            shadow [WORDS];
  mem_port_pkg::mem_rsp_t rsp_q [$];
  int unsigned            due_q [$];
  int unsigned            cyc = 0;
  logic [31:0]            mem_rng = SEED;
  logic [31:0]            stim_rng = SEED;
  logic                   rand_mode = 1'b0;
  logic                   nxt_gnt = 1'b1, nxt_rvalid = 1'b0;
  logic                   nxt_rready = 1'b1, nxt_bready = 1'b1;
  mem_port_pkg::mem_rsp_t nxt_rsp = '0;
  // Expected responses in AXI issue order.
  axi_chan_pkg::r_chan_t  r_exp [$];
  axi_chan_pkg::b_chan_t  b_exp [$];
  int unsigned            r_errs = 0, b_errs = 0, other_errs = 0;

  axi_to_mem axi_to_mem_inst (.*);

  bind axi_to_mem axi_to_mem_chk axi_to_mem_chk_inst (
    .clk_i       ( clk_i           ),
    .arst_n_i    ( arst_n_i        ),
    .req_i       ( mem_req_o       ),
    .req_valid_i ( mem_req_valid_o ),
    .gnt_i       ( mem_gnt_i       ),
    .r_i         ( r_o             ),
    .r_valid_i   ( r_valid_o       ),
    .r_ready_i   ( r_ready_i       ),
    .b_i         ( b_o             ),
    .b_valid_i   ( b_valid_o       ),
    .b_ready_i   ( b_ready_i       )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Preload pattern, unique per word.
  function automatic logic [31:0] fill_word(int unsigned idx);
    return (idx * 32'h9e37_79b1) ^ 32'h5a00_00a5;
  endfunction

  // INCR rule: first beat as given, later beats from the aligned start.
  function automatic axi_chan_pkg::addr_t beat_addr(axi_chan_pkg::addr_t base,
                                                    axi_chan_pkg::size_t size, int unsigned beat);
    axi_chan_pkg::addr_t step;
    step = axi_chan_pkg::addr_t'(1) << size;
    if (beat == 0) begin
      return base;
    end
    return (base & ~(step - 16'd1)) + step * axi_chan_pkg::addr_t'(beat);
  endfunction

  function automatic axi_chan_pkg::r_chan_t ref_read_beat(axi_chan_pkg::id_t id,
                                                          axi_chan_pkg::addr_t addr, logic last);
    axi_chan_pkg::r_chan_t r;
    r.id   = id;
    r.data = shadow[addr[15:2]];
    r.resp = (addr >= ERR_BASE) ? axi_chan_pkg::RESP_SLVERR : axi_chan_pkg::RESP_OKAY;
    r.last = last;
    return r;
  endfunction

  // Error beats leave the shadow untouched; returns the beat's error.
  function automatic logic ref_write_beat(axi_chan_pkg::addr_t addr, logic [31:0] data,
                                          logic [3:0] strb);
    if (addr >= ERR_BASE) begin
      return 1'b1;
    end
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        shadow[addr[15:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
    return 1'b0;
  endfunction

  // Memory model. A grant seen here is taken on the next rising edge.
  always @(negedge clk_i) begin
    mem_port_pkg::mem_rsp_t rsp;
    axi_chan_pkg::addr_t    addr;
    cyc     = cyc + 1;
    mem_rng = lcg_step(mem_rng);
    if (mem_req_valid_o && mem_gnt_i) begin
      addr      = mem_req_o.addr;
      rsp.err   = (addr >= ERR_BASE);
      rsp.rdata = mem[addr[15:2]];
      if (mem_req_o.we && !rsp.err) begin
        for (int b = 0; b < 4; b++) begin
          if (mem_req_o.strb[b]) begin
            mem[addr[15:2]][8*b +: 8] = mem_req_o.wdata[8*b +: 8];
          end
        end
      end
      rsp_q.push_back(rsp);
      due_q.push_back(cyc + (rand_mode ? 32'(mem_rng[18:16]) : 32'd0));
    end
    // Answers leave strictly in grant order.
    nxt_rvalid = 1'b0;
    if (rsp_q.size() != 0 && cyc >= due_q[0]) begin
      nxt_rvalid = 1'b1;
      nxt_rsp    = rsp_q.pop_front();
      void'(due_q.pop_front());
    end
    nxt_gnt    = !rand_mode || mem_rng[24] || mem_rng[27];
    nxt_rready = !rand_mode || mem_rng[29];
    nxt_bready = !rand_mode || mem_rng[30];
  end

  always @(posedge clk_i) begin
    mem_gnt_i    <= nxt_gnt;
    mem_rvalid_i <= nxt_rvalid;
    mem_rsp_i    <= nxt_rsp;
    r_ready_i    <= nxt_rready;
    b_ready_i    <= nxt_bready;
  end

  // Compares each R and B transfer, sampled where the handshake is settled.
  always @(negedge clk_i) begin
    axi_chan_pkg::r_chan_t exp_r;
    axi_chan_pkg::b_chan_t exp_b;
    if (r_valid_o && r_ready_i) begin
      if (r_exp.size() == 0) begin
        $display("Unexpected R beat with id %0h at time %0t", r_o.id, $time);
        other_errs++;
      end else begin
        exp_r = r_exp.pop_front();
        if (r_o !== exp_r) begin
          $display("FAIL %0t: R id %0h data %h resp %0d last %0b, expected %0h %h %0d %0b",
                   $time, r_o.id, r_o.data, r_o.resp, r_o.last,
                   exp_r.id, exp_r.data, exp_r.resp, exp_r.last);
          r_errs++;
        end
      end
    end
    if (b_valid_o && b_ready_i) begin
      if (b_exp.size() == 0) begin
        $display("Unexpected B response with id %0h at time %0t", b_o.id, $time);
        other_errs++;
      end else begin
        exp_b = b_exp.pop_front();
        if (b_o !== exp_b) begin
          $display("FAIL %0t: B id %0h resp %0d, expected id %0h resp %0d",
                   $time, b_o.id, b_o.resp, exp_b.id, exp_b.resp);
          b_errs++;
        end
      end
    end
  end

  task automatic report_timeout(string what);
    $display("Timeout waiting for %s after %0d cycles at time %0t", what, TIMEOUT, $time);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  // Channel 0 is AR, 1 is AW, anything else W.
  function automatic logic ready_of(int ch);
    case (ch)
      0:       return ar_ready_o;
      1:       return aw_ready_o;
      default: return w_ready_o;
    endcase
  endfunction

  // Returns on the rising edge that completes the transfer.
  task automatic wait_handshake(int ch, string what);
    int unsigned t;
    t = 0;
    @(negedge clk_i);
    while (!ready_of(ch)) begin
      t++;
      if (t > TIMEOUT) begin
        report_timeout(what);
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  task automatic send_ar(axi_chan_pkg::ax_chan_t ar);
    @(posedge clk_i);
    ar_i       <= ar;
    ar_valid_i <= 1'b1;
    wait_handshake(0, "AR handshake");
    ar_valid_i <= 1'b0;
  endtask

  task automatic send_aw(axi_chan_pkg::ax_chan_t aw);
    @(posedge clk_i);
    aw_i       <= aw;
    aw_valid_i <= 1'b1;
    wait_handshake(1, "AW handshake");
    aw_valid_i <= 1'b0;
  endtask

  task automatic send_w(axi_chan_pkg::w_chan_t w);
    @(posedge clk_i);
    w_i       <= w;
    w_valid_i <= 1'b1;
    wait_handshake(2, "W handshake");
    w_valid_i <= 1'b0;
  endtask

  task automatic read_burst(axi_chan_pkg::id_t id, axi_chan_pkg::addr_t addr,
                            axi_chan_pkg::len_t len, axi_chan_pkg::size_t size);
    axi_chan_pkg::ax_chan_t ar;
    for (int unsigned i = 0; i <= len; i++) begin
      r_exp.push_back(ref_read_beat(id, beat_addr(addr, size, i), i == len));
    end
    ar.id   = id;
    ar.addr = addr;
    ar.len  = len;
    ar.size = size;
    send_ar(ar);
  endtask

  // Random data and strobes; the B response carries any beat's error.
  task automatic write_burst(axi_chan_pkg::id_t id, axi_chan_pkg::addr_t addr,
                             axi_chan_pkg::len_t len, axi_chan_pkg::size_t size);
    axi_chan_pkg::ax_chan_t aw;
    axi_chan_pkg::w_chan_t  beats [$];
    axi_chan_pkg::w_chan_t  wb;
    axi_chan_pkg::b_chan_t  b;
    logic                   err;
    err = 1'b0;
    for (int unsigned i = 0; i <= len; i++) begin
      stim_rng = lcg_step(stim_rng);
      wb.data  = stim_rng;
      stim_rng = lcg_step(stim_rng);
      wb.strb  = stim_rng[27:24];
      err      = ref_write_beat(beat_addr(addr, size, i), wb.data, wb.strb) || err;
      beats.push_back(wb);
    end
    b.id   = id;
    b.resp = err ? axi_chan_pkg::RESP_SLVERR : axi_chan_pkg::RESP_OKAY;
    b_exp.push_back(b);
    aw.id   = id;
    aw.addr = addr;
    aw.len  = len;
    aw.size = size;
    fork
      send_aw(aw);
      begin
        foreach (beats[j]) begin
          send_w(beats[j]);
        end
      end
    join
  endtask

  task automatic wait_drained();
    int unsigned t;
    t = 0;
    while (r_exp.size() != 0 || b_exp.size() != 0) begin
      t++;
      if (t > TIMEOUT) begin
        report_timeout("outstanding R and B responses");
      end
      @(posedge clk_i);
    end
  endtask

  initial begin
    arst_n_i   = 1'b0;
    ar_i       = '0;
    ar_valid_i = 1'b0;
    aw_i       = '0;
    aw_valid_i = 1'b0;
    w_i        = '0;
    w_valid_i  = 1'b0;
    for (int unsigned i = 0; i < WORDS; i++) begin
      mem[i]    = fill_word(i);
      shadow[i] = fill_word(i);
    end
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // Single-beat read of a preloaded word.
    read_burst(4'h1, 16'h0100, 8'd0, 3'd2);
    wait_drained();
    // Strobed write burst, then word and halfword read-back.
    write_burst(4'h2, 16'h0200, 8'd3, 3'd2);
    wait_drained();
    read_burst(4'h3, 16'h0200, 8'd3, 3'd2);
    read_burst(4'h4, 16'h0202, 8'd3, 3'd1);
    wait_drained();
    // Error on the last beat, error on the first beat with a wrap, then a clean write.
    write_burst(4'h5, 16'heff4, 8'd3, 3'd2);
    write_burst(4'h6, 16'hfffc, 8'd1, 3'd2);
    write_burst(4'h7, 16'h0300, 8'd1, 3'd2);
    read_burst(4'h8, 16'heff8, 8'd3, 3'd2);
    wait_drained();
    // Concurrent traffic under random grant, delay and ready.
    rand_mode <= 1'b1;
    fork
      for (int k = 0; k < 6; k++) begin
        read_burst(axi_chan_pkg::id_t'(k), 16'h0400 + 16'(k * 64), 8'(k + 2), 3'd2);
      end
      for (int k = 0; k < 6; k++) begin
        write_burst(axi_chan_pkg::id_t'(k + 8), 16'h0800 + 16'(k * 64), 8'(k + 1), 3'd2);
      end
    join
    wait_drained();
    // Read back every word the concurrent writes could reach.
    read_burst(4'hf, 16'h0800, 8'd87, 3'd2);
    wait_drained();
    $display("Errors: %0d R, %0d B, %0d other", r_errs, b_errs, other_errs);
    if (r_errs + b_errs + other_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
design/axi_chan_pkg.sv
design/mem_port_pkg.sv
design/beat_fifo.sv
design/rd_burst_gen.sv
design/wr_burst_gen.sv
design/beat_arbiter.sv
design/resp_router.sv
design/axi_to_mem.sv
tests/axi_to_mem_chk.sv
tests/axi_to_mem_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module axi_to_mem_tb -o axi_to_mem_sim
out=$(./obj_dir/axi_to_mem_sim 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"
